/* rtl/vga_display_pkg.sv */
`default_nettype none

package vga_display_pkg;

	////////////////////
	// vector types
	////////////////////

	// screen coordinate, wide enough for 640x480 plus porches
	typedef logic [9:0] coord_t;
	// rgb 3-3-2
	typedef logic [7:0] pixel_t;
	// one expanded dac channel
	typedef logic [7:0] channel_t;
	// two 30x30 images = 1800 entries
	typedef logic [10:0] img_addr_t;
	typedef logic [15:0] res_addr_t;
	// host index inside one image
	typedef logic [15:0] wr_index_t;
	// seven-segment pattern, active low, bit 6 is segment g
	typedef logic [6:0] seg_t;

	////////////////////
	// state encodings
	////////////////////

	// screen tiles, background covers everything else
	typedef enum logic [2:0] {
		region_orig0,
		region_orig1,
		region_res0,
		region_res1,
		region_background
	} region_t;

	typedef enum logic [1:0] {
		h_state_active,
		h_state_front,
		h_state_pulse,
		h_state_back
	} h_state_t;

	typedef enum logic [1:0] {
		v_state_active,
		v_state_front,
		v_state_pulse,
		v_state_back
	} v_state_t;

	////////////////////
	// tile geometry
	////////////////////

	localparam int img_side = 30;
	localparam int img_size = img_side * img_side;
	localparam int res_side = 14;
	localparam int res_size = res_side * res_side;

	// tile origins in pixels
	localparam int orig1_x = 30;
	localparam int res0_x = 61;
	localparam int res1_x = 91;
	localparam int res_y = 1;

	// red 7, green 0, blue 0
	localparam pixel_t background_color = 8'he0;

	// registered coordinate to compositor output
	localparam int pixel_latency = 2;

endpackage

`default_nettype wire

/* rtl/vga_timing.sv */
`timescale 1ns/1ps
`default_nettype none

module vga_timing #(
	// each value is the last count of its phase
	parameter vga_display_pkg::coord_t h_active = 10'd639,
	parameter vga_display_pkg::coord_t h_front = 10'd15,
	parameter vga_display_pkg::coord_t h_pulse = 10'd95,
	parameter vga_display_pkg::coord_t h_back = 10'd47,
	// vertical values count lines
	parameter vga_display_pkg::coord_t v_active = 10'd479,
	parameter vga_display_pkg::coord_t v_front = 10'd9,
	parameter vga_display_pkg::coord_t v_pulse = 10'd1,
	parameter vga_display_pkg::coord_t v_back = 10'd32
) (
	input wire clock,
	input wire reset,
	input wire vga_display_pkg::pixel_t pixel_color,
	output vga_display_pkg::coord_t next_x,
	output vga_display_pkg::coord_t next_y,
	output logic hsync,
	output logic vsync,
	output logic blank_n,
	output vga_display_pkg::channel_t red,
	output vga_display_pkg::channel_t green,
	output vga_display_pkg::channel_t blue
);

	localparam int latency = vga_display_pkg::pixel_latency;

	vga_display_pkg::h_state_t h_state;
	vga_display_pkg::h_state_t h_next;
	vga_display_pkg::v_state_t v_state;
	vga_display_pkg::v_state_t v_next;
	vga_display_pkg::coord_t h_counter;
	vga_display_pkg::coord_t h_last;
	vga_display_pkg::coord_t v_counter;
	vga_display_pkg::coord_t v_last;
	logic line_done;
	logic scan_active;
	// bit 0 lines up with the compositor's first stage
	logic [latency:0] active_pipe;

	////////////////////
	// horizontal
	////////////////////

	// end count and successor of the current phase
	always_comb begin
		h_last = h_active;
		h_next = h_state;
		case (h_state)
			vga_display_pkg::h_state_active: begin
				h_last = h_active;
				h_next = vga_display_pkg::h_state_front;
			end
			vga_display_pkg::h_state_front: begin
				h_last = h_front;
				h_next = vga_display_pkg::h_state_pulse;
			end
			vga_display_pkg::h_state_pulse: begin
				h_last = h_pulse;
				h_next = vga_display_pkg::h_state_back;
			end
			vga_display_pkg::h_state_back: begin
				h_last = h_back;
				h_next = vga_display_pkg::h_state_active;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			h_counter <= '0;
			h_state <= vga_display_pkg::h_state_active;
			line_done <= 1'b0;
			hsync <= 1'b1;
		end else begin
			if (h_counter == h_last) begin
				h_counter <= '0;
				h_state <= h_next;
			end else begin
				h_counter <= h_counter + 10'd1;
			end
			// one early so the vertical side steps with the new line
			line_done <= (h_state == vga_display_pkg::h_state_back)
				&& (h_counter == h_back - 10'd1);
			hsync <= (h_state != vga_display_pkg::h_state_pulse);
		end
	end

	////////////////////
	// vertical
	////////////////////

	always_comb begin
		v_last = v_active;
		v_next = v_state;
		case (v_state)
			vga_display_pkg::v_state_active: begin
				v_last = v_active;
				v_next = vga_display_pkg::v_state_front;
			end
			vga_display_pkg::v_state_front: begin
				v_last = v_front;
				v_next = vga_display_pkg::v_state_pulse;
			end
			vga_display_pkg::v_state_pulse: begin
				v_last = v_pulse;
				v_next = vga_display_pkg::v_state_back;
			end
			vga_display_pkg::v_state_back: begin
				v_last = v_back;
				v_next = vga_display_pkg::v_state_active;
			end
		endcase
	end

	// advances once per line
	always_ff @(posedge clock) begin
		if (reset) begin
			v_counter <= '0;
			v_state <= vga_display_pkg::v_state_active;
			vsync <= 1'b1;
		end else begin
			if (line_done) begin
				if (v_counter == v_last) begin
					v_counter <= '0;
					v_state <= v_next;
				end else begin
					v_counter <= v_counter + 10'd1;
				end
			end
			vsync <= (v_state != vga_display_pkg::v_state_pulse);
		end
	end

	////////////////////
	// scan and colour
	////////////////////

	assign scan_active = (h_state == vga_display_pkg::h_state_active)
		&& (v_state == vga_display_pkg::v_state_active);
	// coordinate whose pixel is fetched now
	assign next_x = (h_state == vga_display_pkg::h_state_active) ? h_counter : '0;
	assign next_y = (v_state == vga_display_pkg::v_state_active) ? v_counter : '0;

	// top bit of the pipe matches pixel_color, outputs one register later
	always_ff @(posedge clock) begin
		if (reset) begin
			active_pipe <= '0;
			blank_n <= 1'b0;
			red <= '0;
			green <= '0;
			blue <= '0;
		end else begin
			active_pipe <= {active_pipe[latency-1:0], scan_active};
			blank_n <= active_pipe[latency];
			if (active_pipe[latency]) begin
				// 3-3-2 into the msbs of each channel
				red <= {pixel_color[7:5], 5'd0};
				green <= {pixel_color[4:2], 5'd0};
				blue <= {pixel_color[1:0], 6'd0};
			end else begin
				red <= '0;
				green <= '0;
				blue <= '0;
			end
		end
	end

endmodule

`default_nettype wire

/* rtl/display_compositor.sv */
`timescale 1ns/1ps
`default_nettype none

module display_compositor (
	input wire clock,
	input wire reset,
	input wire vga_display_pkg::coord_t next_x,
	input wire vga_display_pkg::coord_t next_y,
	output vga_display_pkg::img_addr_t img_rd_addr,
	input wire vga_display_pkg::pixel_t img_rd_data,
	output vga_display_pkg::res_addr_t result_addr,
	input wire vga_display_pkg::pixel_t result_data,
	output vga_display_pkg::pixel_t pixel_color
);

	// exclusive right and bottom edges
	localparam int orig1_end = vga_display_pkg::orig1_x + vga_display_pkg::img_side;
	localparam int res0_end = vga_display_pkg::res0_x + vga_display_pkg::res_side;
	localparam int res1_end = vga_display_pkg::res1_x + vga_display_pkg::res_side;
	localparam int res_y_end = vga_display_pkg::res_y + vga_display_pkg::res_side;

	vga_display_pkg::region_t region;
	vga_display_pkg::region_t region_q;
	vga_display_pkg::region_t region_d;
	vga_display_pkg::img_addr_t img_addr;
	vga_display_pkg::img_addr_t img_row_base;
	vga_display_pkg::res_addr_t res_addr;
	vga_display_pkg::res_addr_t res_row_base;
	logic img_rows;
	logic res_rows;

	////////////////////
	// stage one decode
	////////////////////

	assign img_rows = next_y < vga_display_pkg::img_side;
	assign res_rows = (next_y >= vga_display_pkg::res_y) && (next_y < res_y_end);
	// row offsets, only meaningful inside a tile
	assign img_row_base = vga_display_pkg::img_addr_t'(next_y)
		* vga_display_pkg::img_addr_t'(vga_display_pkg::img_side);
	assign res_row_base = vga_display_pkg::res_addr_t'(next_y - vga_display_pkg::res_y)
		* vga_display_pkg::res_addr_t'(vga_display_pkg::res_side);

	// tiles never overlap so the order is free
	always_comb begin
		region = vga_display_pkg::region_background;
		img_addr = '0;
		res_addr = '0;
		if (img_rows && (next_x < vga_display_pkg::img_side)) begin
			region = vga_display_pkg::region_orig0;
			img_addr = img_row_base + vga_display_pkg::img_addr_t'(next_x);
		end else if (img_rows && (next_x >= vga_display_pkg::orig1_x)
			&& (next_x < orig1_end)) begin
			region = vga_display_pkg::region_orig1;
			// second image sits one full image further on
			img_addr = img_row_base
				+ vga_display_pkg::img_addr_t'(next_x - vga_display_pkg::orig1_x)
				+ vga_display_pkg::img_addr_t'(vga_display_pkg::img_size);
		end else if (res_rows && (next_x >= vga_display_pkg::res0_x)
			&& (next_x < res0_end)) begin
			region = vga_display_pkg::region_res0;
			res_addr = res_row_base
				+ vga_display_pkg::res_addr_t'(next_x - vga_display_pkg::res0_x);
		end else if (res_rows && (next_x >= vga_display_pkg::res1_x)
			&& (next_x < res1_end)) begin
			region = vga_display_pkg::region_res1;
			res_addr = res_row_base
				+ vga_display_pkg::res_addr_t'(next_x - vga_display_pkg::res1_x)
				+ vga_display_pkg::res_addr_t'(vga_display_pkg::res_size);
		end
	end

	// region tag follows the read data through both memories
	always_ff @(posedge clock) begin
		if (reset) begin
			region_q <= vga_display_pkg::region_background;
			region_d <= vga_display_pkg::region_background;
		end else begin
			region_q <= region;
			region_d <= region_q;
		end
	end

	////////////////////
	// address and select
	////////////////////

	always_ff @(posedge clock) begin
		img_rd_addr <= img_addr;
		result_addr <= res_addr;
		// read data is one cycle behind the address
		case (region_d)
			vga_display_pkg::region_orig0,
			vga_display_pkg::region_orig1: pixel_color <= img_rd_data;
			vga_display_pkg::region_res0,
			vga_display_pkg::region_res1: pixel_color <= result_data;
			default: pixel_color <= vga_display_pkg::background_color;
		endcase
	end

endmodule

`default_nettype wire

/* rtl/image_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module image_ram (
	input wire clock,
	input wire wr_en,
	input wire vga_display_pkg::wr_index_t wr_index,
	input wire wr_group,
	input wire vga_display_pkg::pixel_t wr_data,
	input wire vga_display_pkg::img_addr_t rd_addr,
	output vga_display_pkg::pixel_t rd_data
);

	// both input images back to back
	localparam int depth = 2 * vga_display_pkg::img_size;

	vga_display_pkg::pixel_t mem [depth];
	vga_display_pkg::wr_index_t wr_addr;

	////////////////////
	// host write
	////////////////////

	// group 1 lands after the first image
	assign wr_addr = wr_index
		+ (wr_group ? vga_display_pkg::wr_index_t'(vga_display_pkg::img_size) : '0);

	// indices past the end are dropped
	always_ff @(posedge clock) begin
		if (wr_en && (wr_addr < depth)) begin
			mem[vga_display_pkg::img_addr_t'(wr_addr)] <= wr_data;
		end
	end

	////////////////////
	// scan read
	////////////////////

	// one cycle latency, old data on a same-address write
	always_ff @(posedge clock) begin
		rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

/* rtl/status_hex.sv */
`timescale 1ns/1ps
`default_nettype none

module status_hex (
	input wire [7:0] layer_value,
	input wire [7:0] threshold,
	input wire buffer_req,
	input wire [2:0] accel_state,
	output vga_display_pkg::seg_t hex0,
	output vga_display_pkg::seg_t hex1,
	output vga_display_pkg::seg_t hex2,
	output vga_display_pkg::seg_t hex3,
	output vga_display_pkg::seg_t hex4,
	output vga_display_pkg::seg_t hex5
);

	// segment g is bit 6, a lit segment is 0
	function automatic vga_display_pkg::seg_t hex_pattern(input logic [3:0] value);
		vga_display_pkg::seg_t pattern;
		case (value)
			4'h0: pattern = 7'b1000000;
			4'h1: pattern = 7'b1111001;
			4'h2: pattern = 7'b0100100;
			4'h3: pattern = 7'b0110000;
			4'h4: pattern = 7'b0011001;
			4'h5: pattern = 7'b0010010;
			4'h6: pattern = 7'b0000010;
			4'h7: pattern = 7'b1111000;
			4'h8: pattern = 7'b0000000;
			4'h9: pattern = 7'b0010000;
			4'ha: pattern = 7'b0001000;
			4'hb: pattern = 7'b0000011;
			4'hc: pattern = 7'b1000110;
			4'hd: pattern = 7'b0100001;
			4'he: pattern = 7'b0000110;
			default: pattern = 7'b0001110;
		endcase
		return pattern;
	endfunction

	// layer output, low nibble on the right
	assign hex0 = hex_pattern(layer_value[3:0]);
	assign hex1 = hex_pattern(layer_value[7:4]);
	// low threshold byte
	assign hex2 = hex_pattern(threshold[3:0]);
	assign hex3 = hex_pattern(threshold[7:4]);
	// request shows 0 or 1
	assign hex4 = hex_pattern({3'd0, buffer_req});
	assign hex5 = hex_pattern({1'b0, accel_state});

endmodule

`default_nettype wire

/* rtl/vga_display_top.sv */
`timescale 1ns/1ps
`default_nettype none

module vga_display_top #(
	parameter vga_display_pkg::coord_t h_active = 10'd639,
	parameter vga_display_pkg::coord_t h_front = 10'd15,
	parameter vga_display_pkg::coord_t h_pulse = 10'd95,
	parameter vga_display_pkg::coord_t h_back = 10'd47,
	parameter vga_display_pkg::coord_t v_active = 10'd479,
	parameter vga_display_pkg::coord_t v_front = 10'd9,
	parameter vga_display_pkg::coord_t v_pulse = 10'd1,
	parameter vga_display_pkg::coord_t v_back = 10'd32
) (
	input wire clock,
	input wire reset,
	// host image writes
	input wire img_wr_en,
	input wire vga_display_pkg::wr_index_t img_wr_index,
	input wire img_wr_group,
	input wire vga_display_pkg::pixel_t img_wr_data,
	// external result memory, one cycle read
	output wire vga_display_pkg::res_addr_t result_addr,
	input wire vga_display_pkg::pixel_t result_data,
	// accelerator status
	input wire [7:0] layer_value,
	input wire [7:0] threshold,
	input wire buffer_req,
	input wire [2:0] accel_state,
	// vga dac
	output wire hsync,
	output wire vsync,
	output wire blank_n,
	output wire vga_display_pkg::channel_t red,
	output wire vga_display_pkg::channel_t green,
	output wire vga_display_pkg::channel_t blue,
	output wire vga_display_pkg::seg_t hex0,
	output wire vga_display_pkg::seg_t hex1,
	output wire vga_display_pkg::seg_t hex2,
	output wire vga_display_pkg::seg_t hex3,
	output wire vga_display_pkg::seg_t hex4,
	output wire vga_display_pkg::seg_t hex5
);

	vga_display_pkg::coord_t next_x;
	vga_display_pkg::coord_t next_y;
	vga_display_pkg::pixel_t pixel_color;
	vga_display_pkg::img_addr_t img_rd_addr;
	vga_display_pkg::pixel_t img_rd_data;

	vga_timing #(
		.h_active(h_active),
		.h_front(h_front),
		.h_pulse(h_pulse),
		.h_back(h_back),
		.v_active(v_active),
		.v_front(v_front),
		.v_pulse(v_pulse),
		.v_back(v_back)
	) u_timing (
		.clock(clock),
		.reset(reset),
		.pixel_color(pixel_color),
		.next_x(next_x),
		.next_y(next_y),
		.hsync(hsync),
		.vsync(vsync),
		.blank_n(blank_n),
		.red(red),
		.green(green),
		.blue(blue)
	);

	display_compositor u_compositor (
		.clock(clock),
		.reset(reset),
		.next_x(next_x),
		.next_y(next_y),
		.img_rd_addr(img_rd_addr),
		.img_rd_data(img_rd_data),
		.result_addr(result_addr),
		.result_data(result_data),
		.pixel_color(pixel_color)
	);

	image_ram u_image_ram (
		.clock(clock),
		.wr_en(img_wr_en),
		.wr_index(img_wr_index),
		.wr_group(img_wr_group),
		.wr_data(img_wr_data),
		.rd_addr(img_rd_addr),
		.rd_data(img_rd_data)
	);

	status_hex u_status_hex (
		.layer_value(layer_value),
		.threshold(threshold),
		.buffer_req(buffer_req),
		.accel_state(accel_state),
		.hex0(hex0),
		.hex1(hex1),
		.hex2(hex2),
		.hex3(hex3),
		.hex4(hex4),
		.hex5(hex5)
	);

endmodule

`default_nettype wire

/* dv/vga_display_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module vga_display_checker #(
	parameter int h_pulse = 95
) (
	input wire clock,
	input wire reset,
	input wire hsync,
	input wire vsync,
	input wire blank_n,
	input wire vga_display_pkg::channel_t red,
	input wire vga_display_pkg::channel_t green,
	input wire vga_display_pkg::channel_t blue
);

	// pulse phase lasts its last count plus one
	localparam int pulse_len = h_pulse + 1;

	int fail_count = 0;

	////////////////////
	// sync and blanking
	////////////////////

	// no picture during either sync pulse
	sync_blanked: assert property (@(posedge clock) disable iff (reset)
		(!hsync || !vsync) |-> !blank_n)
	else begin
		fail_count++;
		$error("blank_n high while a sync pulse is active");
	end

	// full-width hsync pulse, then high again
	hsync_width: assert property (@(posedge clock) disable iff (reset)
		$fell(hsync) |-> (!hsync) [*pulse_len] ##1 hsync)
	else begin
		fail_count++;
		$error("hsync pulse width differs from h_pulse plus one");
	end

	// dac outputs dark outside the active area
	dark_when_blank: assert property (@(posedge clock) disable iff (reset)
		!blank_n |-> (red == '0) && (green == '0) && (blue == '0))
	else begin
		fail_count++;
		$error("colour output nonzero while blank_n is low");
	end

endmodule

bind vga_timing vga_display_checker #(
	.h_pulse(h_pulse)
) u_checker (
	.clock(clock),
	.reset(reset),
	.hsync(hsync),
	.vsync(vsync),
	.blank_n(blank_n),
	.red(red),
	.green(green),
	.blue(blue)
);

`default_nettype wire

/* dv/vga_display_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module vga_display_tb;

	// small frame, a whole screen fits in a few thousand cycles
	localparam int h_active = 127;
	localparam int h_front = 3;
	localparam int h_pulse = 3;
	localparam int h_back = 3;
	localparam int v_active = 31;
	localparam int v_front = 1;
	localparam int v_pulse = 1;
	localparam int v_back = 1;
	localparam int width = h_active + 1;
	localparam int height = v_active + 1;
	localparam int line_cycles = h_active + h_front + h_pulse + h_back + 4;
	localparam int frame_cycles = line_cycles * (v_active + v_front + v_pulse + v_back + 4);
	localparam int result_depth = 2 * vga_display_pkg::res_size;

	// test ids
	localparam int t_reset = 0;
	localparam int t_timing = 1;
	localparam int t_image = 2;
	localparam int t_result = 3;
	localparam int t_background = 4;
	localparam int t_status = 5;

	logic clock = 1'b0;
	logic reset;
	logic img_wr_en;
	vga_display_pkg::wr_index_t img_wr_index;
	logic img_wr_group;
	vga_display_pkg::pixel_t img_wr_data;
	vga_display_pkg::res_addr_t result_addr;
	vga_display_pkg::pixel_t result_data;
	logic [7:0] layer_value;
	logic [7:0] threshold;
	logic buffer_req;
	logic [2:0] accel_state;
	logic hsync;
	logic vsync;
	logic blank_n;
	vga_display_pkg::channel_t red;
	vga_display_pkg::channel_t green;
	vga_display_pkg::channel_t blue;
	vga_display_pkg::seg_t hex0;
	vga_display_pkg::seg_t hex1;
	vga_display_pkg::seg_t hex2;
	vga_display_pkg::seg_t hex3;
	vga_display_pkg::seg_t hex4;
	vga_display_pkg::seg_t hex5;

	// golden file contents
	int w_group [$];
	int w_index [$];
	logic [7:0] w_data [$];
	logic [19:0] h_inputs [$];
	logic [41:0] h_segs [$];
	int p_x [$];
	int p_y [$];
	logic [7:0] p_pixel [$];

	vga_display_pkg::pixel_t result_mem [result_depth];
	// one entry per blank_n-high cycle of the captured frame
	logic [23:0] frame [width * height];
	integer seed;
	int check_count [6];
	int error_count [6];
	string test_names [6] = '{"reset_state", "line_timing", "image_tiles",
		"result_tiles", "background", "status_hex"};
	logic run_broken = 1'b0;

	vga_display_top #(
		.h_active(h_active),
		.h_front(h_front),
		.h_pulse(h_pulse),
		.h_back(h_back),
		.v_active(v_active),
		.v_front(v_front),
		.v_pulse(v_pulse),
		.v_back(v_back)
	) dut (
		.clock(clock),
		.reset(reset),
		.img_wr_en(img_wr_en),
		.img_wr_index(img_wr_index),
		.img_wr_group(img_wr_group),
		.img_wr_data(img_wr_data),
		.result_addr(result_addr),
		.result_data(result_data),
		.layer_value(layer_value),
		.threshold(threshold),
		.buffer_req(buffer_req),
		.accel_state(accel_state),
		.hsync(hsync),
		.vsync(vsync),
		.blank_n(blank_n),
		.red(red),
		.green(green),
		.blue(blue),
		.hex0(hex0),
		.hex1(hex1),
		.hex2(hex2),
		.hex3(hex3),
		.hex4(hex4),
		.hex5(hex5)
	);

	always #4 clock = ~clock;

	// external result memory, data one cycle after the address
	always @(posedge clock) begin
		if (result_addr < result_depth) begin
			result_data <= result_mem[result_addr];
		end else begin
			result_data <= '0;
		end
	end

	////////////////////
	// helpers
	////////////////////

	task automatic check_value(input int test, input string what,
		input logic [31:0] expected, input logic [31:0] actual);
		check_count[test]++;
		assert (actual === expected) else begin
			$display("[ERROR] %s %s: expected %0h, actual %0h",
				test_names[test], what, expected, actual);
			error_count[test]++;
		end
	endtask

	task automatic finish_test(input int test);
		$display("test %s: %0d checks, %0d errors",
			test_names[test], check_count[test], error_count[test]);
	endtask

	// 3-3-2 into the top bits of each channel
	function automatic logic [23:0] expand_332(input logic [7:0] p);
		return {p[7:5], 5'd0, p[4:2], 5'd0, p[1:0], 6'd0};
	endfunction

	// which test a screen point belongs to
	function automatic int tile_kind(input int x, input int y);
		// orig0 and orig1 sit side by side
		if (y < vga_display_pkg::img_side
			&& x < vga_display_pkg::orig1_x + vga_display_pkg::img_side) begin
			return t_image;
		end
		if (y >= vga_display_pkg::res_y
			&& y < vga_display_pkg::res_y + vga_display_pkg::res_side) begin
			if (x >= vga_display_pkg::res0_x
				&& x < vga_display_pkg::res0_x + vga_display_pkg::res_side) begin
				return t_result;
			end
			if (x >= vga_display_pkg::res1_x
				&& x < vga_display_pkg::res1_x + vga_display_pkg::res_side) begin
				return t_result;
			end
		end
		return t_background;
	endfunction

	// row-major inside a tile, res1 one tile further on
	function automatic int result_index(input int x, input int y);
		int row;
		row = (y - vga_display_pkg::res_y) * vga_display_pkg::res_side;
		if (x >= vga_display_pkg::res1_x) begin
			return row + (x - vga_display_pkg::res1_x) + vga_display_pkg::res_size;
		end
		return row + (x - vga_display_pkg::res0_x);
	endfunction

	task automatic load_golden();
		int fd;
		int status;
		string line;
		byte kind;
		logic [15:0] f0;
		logic [15:0] f1;
		logic [15:0] f2;
		logic [7:0] lv;
		logic [7:0] th;
		logic rq;
		logic [2:0] st;
		logic [6:0] s0;
		logic [6:0] s1;
		logic [6:0] s2;
		logic [6:0] s3;
		logic [6:0] s4;
		logic [6:0] s5;
		fd = $fopen("dv/vga_display_golden.txt", "r");
		if (fd == 0) begin
			$display("could not open dv/vga_display_golden.txt");
			run_broken = 1'b1;
			return;
		end
		while (!$feof(fd)) begin
			status = $fgets(line, fd);
			if (status == 0 || line.len() < 2) begin
				continue;
			end
			kind = line.getc(0);
			case (kind)
				"W": begin
					status = $sscanf(line, "W %h %h %h", f0, f1, f2);
					w_group.push_back(int'(f0));
					w_index.push_back(int'(f1));
					w_data.push_back(f2[7:0]);
				end
				"H": begin
					status = $sscanf(line, "H %h %h %h %h %h %h %h %h %h %h",
						lv, th, rq, st, s0, s1, s2, s3, s4, s5);
					h_inputs.push_back({lv, th, rq, st});
					h_segs.push_back({s5, s4, s3, s2, s1, s0});
				end
				"P": begin
					status = $sscanf(line, "P %h %h %h", f0, f1, f2);
					p_x.push_back(int'(f0));
					p_y.push_back(int'(f1));
					p_pixel.push_back(f2[7:0]);
				end
				// comment lines
				default: begin
				end
			endcase
		end
		$fclose(fd);
	endtask

	////////////////////
	// test steps
	////////////////////

	// outputs stay idle for the first cycles out of reset
	task automatic check_reset_state();
		for (int i = 0; i < 4; i++) begin
			@(negedge clock);
			check_value(t_reset, "hsync", 1, hsync);
			check_value(t_reset, "vsync", 1, vsync);
			check_value(t_reset, "blank_n", 0, blank_n);
			check_value(t_reset, "rgb", 0, {red, green, blue});
		end
		finish_test(t_reset);
	endtask

	task automatic write_images();
		for (int i = 0; i < w_index.size(); i++) begin
			@(posedge clock);
			img_wr_en <= 1'b1;
			img_wr_group <= (w_group[i] != 0);
			img_wr_index <= vga_display_pkg::wr_index_t'(w_index[i]);
			img_wr_data <= w_data[i];
		end
		@(posedge clock);
		img_wr_en <= 1'b0;
	endtask

	task automatic check_status();
		logic [41:0] actual;
		for (int i = 0; i < h_inputs.size(); i++) begin
			@(posedge clock);
			{layer_value, threshold, buffer_req, accel_state} <= h_inputs[i];
			// decoders are combinational, settled by the falling edge
			@(negedge clock);
			actual = {hex5, hex4, hex3, hex2, hex1, hex0};
			for (int d = 0; d < 6; d++) begin
				check_value(t_status, $sformatf("vector %0d hex%0d", i, d),
					h_segs[i][7 * d +: 7], actual[7 * d +: 7]);
			end
		end
		finish_test(t_status);
	endtask

	task automatic wait_vsync(input logic level);
		int cycles;
		cycles = 0;
		while (vsync !== level && cycles < 2 * frame_cycles) begin
			@(negedge clock);
			cycles++;
		end
		if (vsync !== level) begin
			$display("timeout: vsync did not go to %0b within two frames", level);
			run_broken = 1'b1;
		end
	endtask

	// one frame from vsync rise to the next vsync pulse
	task automatic capture_frame();
		int cycles;
		int count;
		int run;
		int lines;
		int last_fall;
		logic prev_blank;
		logic prev_hsync;
		cycles = 0;
		count = 0;
		run = 0;
		lines = 0;
		last_fall = -1;
		prev_blank = 1'b0;
		prev_hsync = hsync;
		while (vsync === 1'b1 && cycles < 2 * frame_cycles) begin
			@(negedge clock);
			cycles++;
			if (blank_n === 1'b1) begin
				// count maps to x and y by the line width
				if (count < width * height) begin
					frame[count] = {red, green, blue};
				end
				count++;
				run++;
			end else if (prev_blank === 1'b1) begin
				check_value(t_timing, $sformatf("active cycles in line %0d", lines), width, run);
				lines++;
				run = 0;
			end
			// hsync fall to fall is one full line
			if (prev_hsync === 1'b1 && hsync === 1'b0) begin
				if (last_fall >= 0) begin
					check_value(t_timing, "line length", line_cycles, cycles - last_fall);
				end
				last_fall = cycles;
			end
			prev_blank = blank_n;
			prev_hsync = hsync;
		end
		if (vsync === 1'b1) begin
			$display("timeout: frame capture never reached the next vsync pulse");
			run_broken = 1'b1;
		end else begin
			check_value(t_timing, "active lines per frame", height, lines);
			finish_test(t_timing);
		end
	endtask

	task automatic check_pixels();
		int kind;
		logic [7:0] expected;
		for (int i = 0; i < p_x.size(); i++) begin
			kind = tile_kind(p_x[i], p_y[i]);
			expected = p_pixel[i];
			if (kind == t_result) begin
				expected = result_mem[result_index(p_x[i], p_y[i])];
			end
			check_value(kind, $sformatf("pixel (%0d,%0d)", p_x[i], p_y[i]),
				expand_332(expected), frame[p_y[i] * width + p_x[i]]);
		end
		finish_test(t_image);
		finish_test(t_result);
		finish_test(t_background);
	endtask

	////////////////////
	// main sequence
	////////////////////

	initial begin
		int total_checks;
		int total_errors;
		int assert_fails;
		reset = 1'b1;
		img_wr_en = 1'b0;
		img_wr_index = '0;
		img_wr_group = 1'b0;
		img_wr_data = '0;
		result_data = '0;
		layer_value = '0;
		threshold = '0;
		buffer_req = 1'b0;
		accel_state = '0;
		seed = 32'he0a6_8b49;
		for (int i = 0; i < result_depth; i++) begin
			result_mem[i] = 8'($random(seed));
		end
		load_golden();
		repeat (8) @(posedge clock);
		reset <= 1'b0;
		check_reset_state();
		if (!run_broken) begin
			write_images();
			check_status();
			// skip the frame that was running during the writes
			wait_vsync(1'b0);
		end
		if (!run_broken) begin
			wait_vsync(1'b1);
		end
		if (!run_broken) begin
			capture_frame();
		end
		if (!run_broken) begin
			check_pixels();
		end
		total_checks = 0;
		total_errors = 0;
		for (int t = 0; t < 6; t++) begin
			total_checks += check_count[t];
			total_errors += error_count[t];
		end
		assert_fails = dut.u_timing.u_checker.fail_count;
		$display("checks %0d, errors %0d, assertion failures %0d",
			total_checks, total_errors, assert_fails);
		if (!run_broken && total_errors == 0 && assert_fails == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* dv/vga_display_golden.txt */
# W group index data | H layer threshold request state hex0 .. hex5 | P x y pixel
# all fields hex; result tile points take their pixel from the result memory model
W 0 000 ff
W 0 01f 1c
W 0 383 03
W 1 000 e3
W 1 03b 49
W 1 2bc 92
H 00 00 0 0 40 40 40 40 40 40
H 3c a7 1 5 46 30 78 08 79 12
H f9 1e 0 7 10 0e 06 79 40 78
H 82 db 1 3 24 00 03 21 79 30
P 00 00 ff
P 01 01 1c
P 1d 1d 03
P 1e 00 e3
P 3b 01 49
P 28 17 92
P 3d 01 00
P 4a 0e 00
P 5b 01 00
P 68 0e 00
P 3c 05 e0
P 3d 0f e0
P 4b 03 e0
P 69 03 e0
P 3d 00 e0
P 7f 1f e0

/* verilog.f */
rtl/vga_display_pkg.sv
rtl/vga_timing.sv
rtl/display_compositor.sv
rtl/image_ram.sv
rtl/status_hex.sv
rtl/vga_display_top.sv
dv/vga_display_checker.sv
dv/vga_display_tb.sv

/* Bender.yml */
package:
  name: vga_display

sources:
  - rtl/vga_display_pkg.sv
  - rtl/vga_timing.sv
  - rtl/display_compositor.sv
  - rtl/image_ram.sv
  - rtl/status_hex.sv
  - rtl/vga_display_top.sv
  - target: test
    files:
      - dv/vga_display_checker.sv
      - dv/vga_display_tb.sv
